/* src/i2s_rx_pkg.sv */
package i2s_rx_pkg;

	// Channel count and I2S framing.
	localparam int num_channels = 4;
	localparam int id_width = 5;
	localparam int sample_width = 24;
	localparam int slot_width = 32;

	// Word and FIFO sizes.
	localparam int word_width = 32;
	localparam int fifo_depth = 16;
	localparam int fifo_addr_width = 4;

	// Words read per drain burst.
	localparam int burst_len = 4;

	// Output word layout.
	// Bits 26 and 25 stay zero.
	localparam int id_lsb = 27;
	localparam int lr_bit = 24;
	localparam int sample_lsb = 0;

	// Counter widths.
	localparam int bit_cnt_width = $clog2(slot_width);
	localparam int burst_cnt_width = $clog2(burst_len + 1);
	localparam int ch_idx_width = $clog2(num_channels);

endpackage

/* src/i2s_fifo_if.sv */
`timescale 1ns/100ps

interface i2s_fifo_if;

	logic rd_en;
	logic [i2s_rx_pkg::word_width-1:0] rdata;
	logic burst_ready;
	logic err_full;
	logic err_empty;

	modport fifo_side (
		input  rd_en,
		output rdata,
		output burst_ready,
		output err_full,
		output err_empty
	);

	// Error flags are read at the top level, not by the drain.
	modport drain_side (
		output rd_en,
		input  rdata,
		input  burst_ready
	);

endinterface

/* src/sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo (
	input  logic clk,
	input  logic rst_n,
	input  logic wr_en,
	input  logic [i2s_rx_pkg::word_width-1:0] wdata,
	i2s_fifo_if.fifo_side rd
);

	logic [i2s_rx_pkg::word_width-1:0] mem [i2s_rx_pkg::fifo_depth];
	logic [i2s_rx_pkg::fifo_addr_width-1:0] wr_ptr;
	logic [i2s_rx_pkg::fifo_addr_width-1:0] rd_ptr;
	logic [i2s_rx_pkg::fifo_addr_width:0] count;
	logic [i2s_rx_pkg::word_width-1:0] rdata_q;
	logic burst_ready_q;
	logic err_full_q;
	logic err_empty_q;
	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	assign full = (count == i2s_rx_pkg::fifo_depth);
	assign empty = (count == '0);
	assign do_wr = wr_en && !full;
	assign do_rd = rd.rd_en && !empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	// Popped word, held until the next pop.
	always_ff @(posedge clk) begin
		if (do_rd) begin
			rdata_q <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			burst_ready_q <= 1'b0;
			err_full_q <= 1'b0;
			err_empty_q <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// Lags the count by one cycle.
			burst_ready_q <= (count >= i2s_rx_pkg::burst_len);

			// Sticky until reset.
			if (wr_en && full) begin
				err_full_q <= 1'b1;
			end
			if (rd.rd_en && empty) begin
				err_empty_q <= 1'b1;
			end
		end
	end

	assign rd.rdata = rdata_q;
	assign rd.burst_ready = burst_ready_q;
	assign rd.err_full = err_full_q;
	assign rd.err_empty = err_empty_q;

endmodule

/* src/i2s_receiver.sv */
`timescale 1ns/100ps

module i2s_receiver (
	input  logic clk,
	input  logic rst_n,
	input  logic bclk,
	input  logic lrclk,
	input  logic sdata,
	input  logic [i2s_rx_pkg::id_width-1:0] channel_id,
	i2s_fifo_if.fifo_side rd
);

	logic [1:0] bclk_sync;
	logic [1:0] lrclk_sync;
	logic [1:0] sdata_sync;
	logic bclk_prev;
	logic bclk_rise;
	logic lr_last;
	logic lr_change;
	logic [i2s_rx_pkg::bit_cnt_width-1:0] bit_cnt;
	logic [i2s_rx_pkg::sample_width-1:0] shift;
	logic wr_en;
	logic [i2s_rx_pkg::word_width-1:0] word;

	// Two-flop synchronizers and registered bclk rise.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bclk_sync <= '0;
			lrclk_sync <= '0;
			sdata_sync <= '0;
			bclk_prev <= 1'b0;
			bclk_rise <= 1'b0;
		end else begin
			bclk_sync <= {bclk_sync[0], bclk};
			lrclk_sync <= {lrclk_sync[0], lrclk};
			sdata_sync <= {sdata_sync[0], sdata};
			bclk_prev <= bclk_sync[1];
			bclk_rise <= bclk_sync[1] && !bclk_prev;
		end
	end

	assign lr_change = (lrclk_sync[1] != lr_last);

	// Edge 0 of a slot is the I2S delay bit; bits 1 to 24 carry the sample.
	// Starting with lr_last high lets a left slot open right after reset.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lr_last <= 1'b1;
			bit_cnt <= i2s_rx_pkg::bit_cnt_width'(i2s_rx_pkg::slot_width - 1);
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (bclk_rise) begin
				if (lr_change) begin
					lr_last <= lrclk_sync[1];
					bit_cnt <= '0;
				end else begin
					if (bit_cnt != i2s_rx_pkg::slot_width - 1) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
					if (bit_cnt == i2s_rx_pkg::sample_width - 1) begin
						wr_en <= 1'b1;
					end
				end
			end
		end
	end

	// MSB first.
	always_ff @(posedge clk) begin
		if (bclk_rise && !lr_change && bit_cnt < i2s_rx_pkg::sample_width) begin
			shift <= {shift[i2s_rx_pkg::sample_width-2:0], sdata_sync[1]};
		end
	end

	always_comb begin
		word = '0;
		word[i2s_rx_pkg::id_lsb +: i2s_rx_pkg::id_width] = channel_id;
		word[i2s_rx_pkg::lr_bit] = lr_last;
		word[i2s_rx_pkg::sample_lsb +: i2s_rx_pkg::sample_width] = shift;
	end

	sample_fifo i_sample_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr_en (wr_en),
		.wdata (word),
		.rd    (rd)
	);

endmodule

/* src/burst_drain.sv */
`timescale 1ns/100ps

module burst_drain (
	input  logic clk,
	input  logic rst_n,
	i2s_fifo_if.drain_side ch [i2s_rx_pkg::num_channels],
	output logic wen,
	output logic [i2s_rx_pkg::word_width-1:0] wdata
);

	logic [i2s_rx_pkg::num_channels-1:0] ready_vec;
	logic [i2s_rx_pkg::word_width-1:0] rdata_arr [i2s_rx_pkg::num_channels];
	logic [i2s_rx_pkg::num_channels-1:0] rd_en_q;
	logic in_burst;
	logic [i2s_rx_pkg::ch_idx_width-1:0] idx;
	logic [i2s_rx_pkg::ch_idx_width-1:0] next_idx;
	logic [i2s_rx_pkg::ch_idx_width-1:0] rd_idx;
	logic [i2s_rx_pkg::ch_idx_width-1:0] pop_idx;
	logic [i2s_rx_pkg::burst_cnt_width-1:0] burst_cnt;
	logic pop_d;

	// Interface array to plain vectors for indexed access.
	for (genvar i = 0; i < i2s_rx_pkg::num_channels; i++) begin : g_ch
		assign ready_vec[i] = ch[i].burst_ready;
		assign rdata_arr[i] = ch[i].rdata;
		assign ch[i].rd_en = rd_en_q[i];
	end

	assign next_idx = (idx == i2s_rx_pkg::ch_idx_width'(i2s_rx_pkg::num_channels - 1)) ?
		'0 : idx + 1'b1;

	// Scan one channel per cycle; in burst, burst_len pops then one advance cycle.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			in_burst <= 1'b0;
			idx <= '0;
			rd_idx <= '0;
			burst_cnt <= '0;
			rd_en_q <= '0;
		end else begin
			rd_en_q <= '0;
			if (!in_burst) begin
				if (ready_vec[idx]) begin
					in_burst <= 1'b1;
					burst_cnt <= '0;
				end else begin
					idx <= next_idx;
				end
			end else if (burst_cnt != i2s_rx_pkg::burst_len) begin
				rd_en_q[idx] <= 1'b1;
				rd_idx <= idx;
				burst_cnt <= burst_cnt + 1'b1;
			end else begin
				idx <= next_idx;
				in_burst <= 1'b0;
			end
		end
	end

	// Word is valid on rdata the cycle after its pop.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pop_d <= 1'b0;
			pop_idx <= '0;
			wen <= 1'b0;
		end else begin
			pop_d <= |rd_en_q;
			pop_idx <= rd_idx;
			wen <= pop_d;
		end
	end

	always_ff @(posedge clk) begin
		if (pop_d) begin
			wdata <= rdata_arr[pop_idx];
		end
	end

endmodule

/* src/i2s_rx_array.sv */
`timescale 1ns/100ps

module i2s_rx_array (
	input  logic clk,
	input  logic rst_n,
	input  logic [i2s_rx_pkg::num_channels-1:0] bclk,
	input  logic [i2s_rx_pkg::num_channels-1:0] lrclk,
	input  logic [i2s_rx_pkg::num_channels-1:0] sdata,
	output logic wen,
	output logic [i2s_rx_pkg::word_width-1:0] wdata,
	output logic [i2s_rx_pkg::num_channels-1:0] r_ready,
	output logic [i2s_rx_pkg::num_channels-1:0] error_full,
	output logic [i2s_rx_pkg::num_channels-1:0] error_empty
);

	i2s_fifo_if fifo_if [i2s_rx_pkg::num_channels] ();

	for (genvar g = 0; g < i2s_rx_pkg::num_channels; g++) begin : g_rx
		// Channel tag is the generate index.
		i2s_receiver i_i2s_receiver (
			.clk        (clk),
			.rst_n      (rst_n),
			.bclk       (bclk[g]),
			.lrclk      (lrclk[g]),
			.sdata      (sdata[g]),
			.channel_id (i2s_rx_pkg::id_width'(g)),
			.rd         (fifo_if[g])
		);

		assign r_ready[g] = fifo_if[g].burst_ready;
		assign error_full[g] = fifo_if[g].err_full;
		assign error_empty[g] = fifo_if[g].err_empty;
	end

	burst_drain i_burst_drain (
		.clk   (clk),
		.rst_n (rst_n),
		.ch    (fifo_if),
		.wen   (wen),
		.wdata (wdata)
	);

endmodule

/* tests/i2s_rx_array_checker.sv */
`timescale 1ns/100ps

module i2s_rx_array_checker (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input logic [i2s_rx_pkg::word_width-1:0] wdata,
	input logic [i2s_rx_pkg::num_channels-1:0] error_full,
	input logic [i2s_rx_pkg::num_channels-1:0] error_empty
);

	int run_len;
	logic [i2s_rx_pkg::id_width-1:0] run_id;
	int failures = 0;

	// Length and channel of the wen run so far.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_len <= 0;
			run_id <= '0;
		end else if (wen) begin
			run_len <= run_len + 1;
			if (run_len == 0) begin
				run_id <= wdata[31:27];
			end
		end else begin
			run_len <= 0;
		end
	end

	// Quiet in reset and on the first cycle after.
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !wen)
		else begin
			failures++;
			$error("wen was high during or right after reset");
		end

	run_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
		wen |-> run_len < i2s_rx_pkg::burst_len)
		else begin
			failures++;
			$error("wen run longer than one burst");
		end

	run_not_too_short: assert property (@(posedge clk) disable iff (!rst_n)
		(!wen && run_len != 0) |-> run_len == i2s_rx_pkg::burst_len)
		else begin
			failures++;
			$error("wen run of %0d words ended before a full burst", run_len);
		end

	run_single_channel: assert property (@(posedge clk) disable iff (!rst_n)
		(wen && run_len != 0) |-> wdata[31:27] == run_id)
		else begin
			failures++;
			$error("channel id changed within a burst");
		end

	no_overflow: assert property (@(posedge clk) disable iff (!rst_n) error_full == '0)
		else begin
			failures++;
			$error("a channel FIFO overflowed");
		end

	no_underflow: assert property (@(posedge clk) disable iff (!rst_n) error_empty == '0)
		else begin
			failures++;
			$error("a channel FIFO was read while empty");
		end

endmodule

bind i2s_rx_array i2s_rx_array_checker i_checker (.*);

/* tests/i2s_rx_array_tb.sv */
`timescale 1ns/100ps

module i2s_rx_array_tb;

	localparam int nch = i2s_rx_pkg::num_channels;
	localparam int frames = 8;
	localparam int samples_per_channel = 2 * frames;
	// 8 frames of 512 cycles, plus reset and drain margin.
	localparam int timeout_cycles = 6000;

	logic clk;
	logic rst_n;
	logic [nch-1:0] bclk;
	logic [nch-1:0] lrclk;
	logic [nch-1:0] sdata;
	logic wen;
	logic [31:0] wdata;
	logic [nch-1:0] r_ready;
	logic [nch-1:0] error_full;
	logic [nch-1:0] error_empty;

	logic [23:0] samples [nch][samples_per_channel];
	logic [31:0] expected_q [nch][$];
	logic next_lr [nch];
	bit ready_seen [nch];
	logic [15:0] lfsr_state;
	int cycles = 0;
	int run_pos = 0;
	int burst_id = 0;
	bit seen_burst = 1'b0;

	i2s_rx_array i_i2s_rx_array (
		.clk         (clk),
		.rst_n       (rst_n),
		.bclk        (bclk),
		.lrclk       (lrclk),
		.sdata       (sdata),
		.wen         (wen),
		.wdata       (wdata),
		.r_ready     (r_ready),
		.error_full  (error_full),
		.error_empty (error_empty)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1, "Simulation stopped after a failure.");
	endtask

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		logic [15:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 16'hB400;
		end
		return next;
	endfunction

	// Id in 31:27, lr flag in 24, sample in 23:0.
	function automatic logic [31:0] make_word(input int ch, input logic lr,
		input logic [23:0] sample);
		logic [31:0] w;
		w = '0;
		w[31:27] = ch[4:0];
		w[24] = lr;
		w[23:0] = sample;
		return w;
	endfunction

	function automatic bit all_delivered();
		for (int ch = 0; ch < nch; ch++) begin
			if (expected_q[ch].size() != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic prepare_samples();
		logic [23:0] s;
		for (int n = 0; n < samples_per_channel; n++) begin
			for (int ch = 0; ch < nch; ch++) begin
				s = '0;
				for (int b = 0; b < 24; b++) begin
					lfsr_state = lfsr_step(lfsr_state);
					s = {s[22:0], lfsr_state[0]};
				end
				samples[ch][n] = s;
				expected_q[ch].push_back(make_word(ch, (n % 2) == 1, s));
			end
		end
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clk);
		#1;
	endtask

	// I2S transmitter with a bclk of 8 clk cycles and 32-bit slots.
	// lrclk and data change on falling bclk, MSB one bclk after lrclk.
	task automatic transmit_channel(input int ch);
		logic [23:0] s;
		for (int n = 0; n < samples_per_channel; n++) begin
			s = samples[ch][n];
			for (int b = 0; b < 32; b++) begin
				bclk[ch] = 1'b0;
				if (b == 0) begin
					lrclk[ch] = (n % 2) == 1;
				end
				if (b >= 1 && b <= 24) begin
					sdata[ch] = s[24 - b];
				end else begin
					sdata[ch] = 1'b0;
				end
				wait_cycles(4);
				bclk[ch] = 1'b1;
				wait_cycles(4);
			end
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			stop_with_failure($sformatf("Run timed out after %0d cycles.", cycles));
		end
	end

	always @(negedge clk) begin
		int id;
		logic [31:0] expected_word;
		assert (i_i2s_rx_array.i_checker.failures == 0)
			else stop_with_failure("An assertion in the bound checker failed.");
		for (int ch = 0; ch < nch; ch++) begin
			if (r_ready[ch]) begin
				ready_seen[ch] = 1'b1;
			end
		end
		if (rst_n && wen) begin
			id = int'(wdata[31:27]);
			assert (id < nch)
				else stop_with_failure($sformatf(
					"CHECK FAILED channel_id: expected below %0d, actual %0d", nch, id));
			assert (expected_q[id].size() > 0)
				else stop_with_failure($sformatf(
					"Channel %0d delivered more words than were transmitted.", id));
			assert (wdata[24] == next_lr[id])
				else stop_with_failure($sformatf(
					"CHECK FAILED lr_alternation: expected %0b, actual %0b",
					next_lr[id], wdata[24]));
			next_lr[id] = !next_lr[id];
			expected_word = expected_q[id].pop_front();
			assert (wdata == expected_word)
				else stop_with_failure($sformatf(
					"CHECK FAILED data_integrity: expected %h, actual %h",
					expected_word, wdata));
			// First word of a burst sets the channel of the whole run.
			if (run_pos == 0) begin
				assert (ready_seen[id])
					else stop_with_failure($sformatf(
						"Channel %0d started a burst without raising r_ready.", id));
				ready_seen[id] = 1'b0;
				if (seen_burst) begin
					assert (id == (burst_id + 1) % nch)
						else stop_with_failure($sformatf(
							"CHECK FAILED round_robin: expected %0d, actual %0d",
							(burst_id + 1) % nch, id));
				end
				seen_burst = 1'b1;
				burst_id = id;
			end
			run_pos = (run_pos + 1) % i2s_rx_pkg::burst_len;
		end
	end

	initial begin
		rst_n = 1'b0;
		bclk = '0;
		lrclk = '1;
		sdata = '0;
		lfsr_state = 16'd90;
		for (int ch = 0; ch < nch; ch++) begin
			next_lr[ch] = 1'b0;
			ready_seen[ch] = 1'b0;
		end
		prepare_samples();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		fork
			transmit_channel(0);
			transmit_channel(1);
			transmit_channel(2);
			transmit_channel(3);
		join
		while (!all_delivered()) begin
			@(negedge clk);
		end
		repeat (8) @(negedge clk);
		if (i_i2s_rx_array.i_checker.failures == 0 && error_full == '0
			&& error_empty == '0 && r_ready == '0) begin
			$display("Everything OK");
			$finish;
		end else begin
			stop_with_failure("Error flags, r_ready or checker assertions were not clear at the end.");
		end
	end

endmodule

/* compile.f */
src/i2s_rx_pkg.sv
src/i2s_fifo_if.sv
src/sample_fifo.sv
src/i2s_receiver.sv
src/burst_drain.sv
src/i2s_rx_array.sv
tests/i2s_rx_array_checker.sv
tests/i2s_rx_array_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f \
	--top-module i2s_rx_array_tb -o sim_i2s_rx_array

# A failing run still leaves its log for the search below.
./obj_dir/sim_i2s_rx_array +verilator+error+limit+10 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "Simulation passed."
else
	echo "Simulation failed."
	exit 1
fi
